/* build.f */
logic/rv32i_isa_pkg.sv
logic/alu_types_pkg.sv
logic/alu_ctrl.sv
logic/alu_arith.sv
logic/alu_lsu_wb.sv
logic/alu_top.sv
tb/alu_ctrl_assertions.sv
tb/tb_alu.sv

/* logic/alu_arith.sv */
////////////////////
// Combinational integer unit: R-type and I-type operations and LUI,
// result goes to the writeback merge
////////////////////

`timescale 1ns/1ps

module alu_arith
    import rv32i_isa_pkg::*;
    import alu_types_pkg::*;
(
    input  instr_t instr,
    input  word_t  rs1_val,
    input  word_t  rs2_val,
    output word_t  exec_val
);

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;
    logic    is_reg;
    word_t   imm_i;
    word_t   imm_u;
    word_t   op_b;
    shamt_t  shamt;
    word_t   arith_res;

    ////////////////////
    // Operand selection
    ////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[FUNCT7_ALT_BIT];

    // Opcode bit 5 tells R-type from I-type
    assign is_reg = opcode[5];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign op_b   = is_reg ? rs2_val : imm_i;
    assign shamt  = op_b[4:0];

    ////////////////////
    // Operations
    ////////////////////

    always_comb begin
        case (funct3)
            F3_ADD: begin
                // Immediate forms never subtract
                if (is_reg && alt) begin
                    arith_res = rs1_val - op_b;
                end else begin
                    arith_res = rs1_val + op_b;
                end
            end
            F3_SLL:  arith_res = rs1_val << shamt;
            F3_SLT:  arith_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
            F3_SLTU: arith_res = {31'b0, rs1_val < op_b};
            F3_XOR:  arith_res = rs1_val ^ op_b;
            F3_SR: begin
                if (alt) begin
                    arith_res = word_t'($signed(rs1_val) >>> shamt);
                end else begin
                    arith_res = rs1_val >> shamt;
                end
            end
            F3_OR:   arith_res = rs1_val | op_b;
            F3_AND:  arith_res = rs1_val & op_b;
            default: arith_res = '0;
        endcase
    end

    assign exec_val = (opcode == OPC_LUI) ? imm_u : arith_res;

endmodule

/* logic/alu_ctrl.sv */
////////////////////
// Sequencing of each instruction: acknowledge towards the requester,
// data memory request and the register write enable
////////////////////

`timescale 1ns/1ps

module alu_ctrl
    import rv32i_isa_pkg::*;
    import alu_types_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,
    input  logic    alu_en,
    input  opcode_t opcode,
    input  logic    mem_ready,
    output logic    alu_ready,
    output logic    rd_wr,
    output logic    rd_from_mem,
    output logic    mem_en,
    output logic    mem_wr
);

    ctrl_state_t state;
    logic        is_load;
    logic        is_store;
    logic        is_mem;
    logic        is_exec;
    logic        mem_done;

    // Opcode classes
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_mem   = is_load | is_store;
    assign is_exec  = (opcode == OPC_ARITH_R) | (opcode == OPC_ARITH_I) | (opcode == OPC_LUI);

    ////////////////////
    // Memory wait FSM
    ////////////////////

    // Request stays up while a transfer is pending
    assign mem_en   = (state == ST_MEM_WAIT) | (alu_en & is_mem);
    assign mem_wr   = mem_en & is_store;
    assign mem_done = mem_en & mem_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem_en && !mem_ready) begin
                        state <= ST_MEM_WAIT;
                    end
                end
                ST_MEM_WAIT: begin
                    if (mem_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // Acknowledge and writeback
    ////////////////////

    // Non-memory opcodes, including unsupported ones, finish at once
    assign alu_ready   = alu_en & (is_mem ? mem_done : 1'b1);
    assign rd_wr       = alu_ready & (is_exec | is_load);
    assign rd_from_mem = is_load;

endmodule

/* logic/alu_lsu_wb.sv */
////////////////////
// Load/store datapath: address, write strobes, load extension,
// and the final choice of the register write value
////////////////////

`timescale 1ns/1ps

module alu_lsu_wb
    import rv32i_isa_pkg::*;
    import alu_types_pkg::*;
#(
    parameter int ADDRW = 16
) (
    input  instr_t           instr,
    input  word_t            rs1_val,
    input  word_t            rs2_val,
    input  word_t            exec_val,
    input  logic             rd_from_mem,
    input  word_t            mem_rdata,
    output logic [ADDRW-1:0] mem_addr,
    output word_t            mem_wdata,
    output strb_t            mem_strb,
    output word_t            rd_val,
    output strb_t            rd_strb
);

    opcode_t opcode;
    funct3_t funct3;
    word_t   imm_i;
    word_t   imm_s;
    word_t   addr;
    strb_t   size_strb;
    word_t   load_val;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Store immediate is split around the rd field
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign addr      = rs1_val + ((opcode == OPC_STORE) ? imm_s : imm_i);
    assign mem_addr  = addr[ADDRW-1:0];
    assign mem_wdata = rs2_val;
    assign mem_strb  = size_strb;

    always_comb begin
        case (funct3)
            F3_B, F3_BU: size_strb = 4'b0001;
            F3_H, F3_HU: size_strb = 4'b0011;
            F3_W:        size_strb = 4'b1111;
            default:     size_strb = 4'b0000;
        endcase
    end

    ////////////////////
    // Load extension and merge
    ////////////////////

    always_comb begin
        case (funct3)
            F3_B:    load_val = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            F3_BU:   load_val = {24'b0, mem_rdata[7:0]};
            F3_H:    load_val = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            F3_HU:   load_val = {16'b0, mem_rdata[15:0]};
            default: load_val = mem_rdata;
        endcase
    end

    assign rd_val  = rd_from_mem ? load_val : exec_val;
    assign rd_strb = rd_from_mem ? size_strb : '1;

endmodule

/* logic/alu_top.sv */
////////////////////
// RV32I execution unit top level, instantiated by the core with
// the register file query ports and a data memory port
////////////////////

`timescale 1ns/1ps

module alu_top
    import rv32i_isa_pkg::*;
    import alu_types_pkg::*;
#(
    parameter int ADDRW = 16
) (
    input  logic             aclk,
    input  logic             aresetn,
    // Instruction handshake
    input  logic             alu_en,
    output logic             alu_ready,
    input  instr_t           alu_instr,
    // Register file query
    output reg_idx_t         rs1_addr,
    input  word_t            rs1_val,
    output reg_idx_t         rs2_addr,
    input  word_t            rs2_val,
    // Writeback
    output logic             rd_wr,
    output reg_idx_t         rd_addr,
    output word_t            rd_val,
    output strb_t            rd_strb,
    // Data memory
    output logic             mem_en,
    output logic             mem_wr,
    output logic [ADDRW-1:0] mem_addr,
    output word_t            mem_wdata,
    output strb_t            mem_strb,
    input  word_t            mem_rdata,
    input  logic             mem_ready
);

    opcode_t opcode;
    logic    rd_from_mem;
    word_t   exec_val;

    // Register indexes come straight from the encoding
    assign opcode   = alu_instr[6:0];
    assign rs1_addr = alu_instr[19:15];
    assign rs2_addr = alu_instr[24:20];
    assign rd_addr  = alu_instr[11:7];

    alu_ctrl i_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .alu_en      (alu_en),
        .opcode      (opcode),
        .mem_ready   (mem_ready),
        .alu_ready   (alu_ready),
        .rd_wr       (rd_wr),
        .rd_from_mem (rd_from_mem),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr)
    );

    alu_arith i_arith (
        .instr    (alu_instr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .exec_val (exec_val)
    );

    alu_lsu_wb #(
        .ADDRW (ADDRW)
    ) i_lsu_wb (
        .instr       (alu_instr),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .exec_val    (exec_val),
        .rd_from_mem (rd_from_mem),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_strb    (mem_strb),
        .rd_val      (rd_val),
        .rd_strb     (rd_strb)
    );

endmodule

/* logic/alu_types_pkg.sv */
////////////////////
// Datapath widths and types of the execution unit, plus the
// state encoding of its control FSM
////////////////////

package alu_types_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [XLEN/8-1:0] strb_t;
    typedef logic [4:0]        shamt_t;

    // Control FSM states
    typedef enum logic {
        ST_IDLE,
        ST_MEM_WAIT
    } ctrl_state_t;

endpackage

/* logic/rv32i_isa_pkg.sv */
////////////////////
// RV32I instruction encoding: field types, major opcodes and
// funct3 codes, imported by the decode logic of the execution unit
////////////////////

package rv32i_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes handled by the unit
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_ARITH_I = 7'b0010011;
    localparam opcode_t OPC_ARITH_R = 7'b0110011;

    // Integer operations
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Load and store access sizes
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // Instruction bit inside funct7 that turns ADD into SUB and SRL into SRA
    localparam int FUNCT7_ALT_BIT = 30;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile the execution unit testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_alu -Mdir "$BUILD_DIR" -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_alu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* tb/alu_ctrl_assertions.sv */
////////////////////
// Concurrent checks on the control handshake, bound into alu_ctrl
////////////////////

`timescale 1ns/1ps

module alu_ctrl_assertions (
    input logic aclk,
    input logic aresetn,
    input logic alu_en,
    input logic alu_ready,
    input logic rd_wr,
    input logic mem_en,
    input logic mem_ready
);

    // A register write only comes with the acknowledge
    assert property (@(posedge aclk) disable iff (!aresetn) rd_wr |-> alu_ready)
        else $error("rd_wr high without alu_ready");

    // Stalled memory request is held
    assert property (@(posedge aclk) disable iff (!aresetn) mem_en && !mem_ready |=> mem_en)
        else $error("mem_en dropped before mem_ready");

    assert property (@(posedge aclk) disable iff (!aresetn) !(alu_ready && !alu_en))
        else $error("alu_ready high while alu_en is low");

endmodule

/* tb/tb_alu.sv */
////////////////////
// Directed testbench of the execution unit with register file and
// data memory models, run as the simulation top
////////////////////

`timescale 1ns/1ps

module tb_alu
    import rv32i_isa_pkg::*;
    import alu_types_pkg::*;
();

    localparam int       ADDRW      = 16;
    localparam int       MAX_CYCLES = 4000;
    localparam int       MAX_WAIT   = 20;
    localparam reg_idx_t RS1_IDX    = 5'd3;
    localparam reg_idx_t RS2_IDX    = 5'd7;

    logic             aclk;
    logic             aresetn;
    logic             alu_en;
    logic             alu_ready;
    instr_t           alu_instr;
    reg_idx_t         rs1_addr;
    reg_idx_t         rs2_addr;
    word_t            rs1_val;
    word_t            rs2_val;
    logic             rd_wr;
    reg_idx_t         rd_addr;
    word_t            rd_val;
    strb_t            rd_strb;
    logic             mem_en;
    logic             mem_wr;
    logic [ADDRW-1:0] mem_addr;
    word_t            mem_wdata;
    strb_t            mem_strb;
    word_t            mem_rdata;
    logic             mem_ready;

    word_t       regs [32];
    logic [7:0]  mem [2**ADDRW];
    int unsigned mem_wait;
    int unsigned wait_cnt = 0;
    int unsigned cycles = 0;
    int          errors;
    logic [31:0] rng;

    alu_top #(
        .ADDRW (ADDRW)
    ) i_dut (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .alu_en    (alu_en),
        .alu_ready (alu_ready),
        .alu_instr (alu_instr),
        .rs1_addr  (rs1_addr),
        .rs1_val   (rs1_val),
        .rs2_addr  (rs2_addr),
        .rs2_val   (rs2_val),
        .rd_wr     (rd_wr),
        .rd_addr   (rd_addr),
        .rd_val    (rd_val),
        .rd_strb   (rd_strb),
        .mem_en    (mem_en),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    bind alu_ctrl alu_ctrl_assertions i_ctrl_assertions (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .alu_en    (alu_en),
        .alu_ready (alu_ready),
        .rd_wr     (rd_wr),
        .mem_en    (mem_en),
        .mem_ready (mem_ready)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // Register file and memory models
    ////////////////////

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    function automatic word_t mem_word(input logic [15:0] a);
        return {mem[a + 16'd3], mem[a + 16'd2], mem[a + 16'd1], mem[a]};
    endfunction

    always_comb mem_rdata = mem_word(mem_addr);

    // Ready after mem_wait cycles of a pending request
    assign mem_ready = mem_en && (wait_cnt == mem_wait);

    always @(posedge aclk) begin
        if (mem_en && mem_ready) begin
            wait_cnt <= 0;
            if (mem_wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_strb[i]) begin
                        mem[mem_addr + 16'(i)] = mem_wdata[8*i +: 8];
                    end
                end
            end
        end else if (mem_en) begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    ////////////////////
    // Reference helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic instr_t enc_r(input logic alt, input funct3_t f3, input reg_idx_t rd);
        return {1'b0, alt, 5'b0, RS2_IDX, RS1_IDX, f3, rd, OPC_ARITH_R};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input funct3_t f3,
                                     input reg_idx_t rd, input opcode_t opc);
        return {imm, RS1_IDX, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input funct3_t f3);
        return {imm[11:5], RS2_IDX, RS1_IDX, f3, imm[4:0], OPC_STORE};
    endfunction

    // Standard RV32I result with b as the extended immediate
    function automatic word_t ref_op(input funct3_t f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR: begin
                if (alt && a[31]) begin
                    return (a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]);
                end
                return a >> b[4:0];
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic strb_t lane_mask(input funct3_t f3);
        case (f3[1:0])
            2'b00:   return 4'b0001;
            2'b01:   return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t load_ext(input funct3_t f3, input word_t d);
        case (f3)
            F3_B:    return {{24{d[7]}}, d[7:0]};
            F3_BU:   return {24'h0, d[7:0]};
            F3_H:    return {{16{d[15]}}, d[15:0]};
            F3_HU:   return {16'h0, d[15:0]};
            default: return d;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // Handshake tasks
    ////////////////////

    task automatic issue(input instr_t instr, input word_t a, input word_t b);
        @(posedge aclk);
        #1;
        regs[RS1_IDX] = a;
        regs[RS2_IDX] = b;
        alu_instr     = instr;
        alu_en        = 1'b1;
    endtask

    // Samples at falling edges until the acknowledge and counts stall cycles
    task automatic wait_ready(output int waited);
        waited = 0;
        @(negedge aclk);
        while (!alu_ready && waited < MAX_WAIT) begin
            assert (!rd_wr && !mem_ready) else begin
                $display("rd_wr or mem_ready high while alu_ready is low");
                errors++;
            end
            waited++;
            @(negedge aclk);
        end
        assert (alu_ready) else begin
            $display("alu_ready did not rise within %0d cycles", MAX_WAIT);
            errors++;
        end
    endtask

    task automatic release_instr();
        @(posedge aclk);
        #1;
        alu_en    = 1'b0;
        alu_instr = '0;
    endtask

    task automatic run_exec(input instr_t instr, input reg_idx_t rd, input word_t a,
                            input word_t b, input word_t exp);
        int waited;
        issue(instr, a, b);
        wait_ready(waited);
        check_word("rd_val", rd_val, exp);
        check_bit("rd_wr", rd_wr, 1'b1);
        check_bit("mem_en", mem_en, 1'b0);
        check_word("rd_strb", word_t'(rd_strb), 32'hf);
        check_word("rd_addr", word_t'(rd_addr), word_t'(rd));
        check_word("latency", waited, 0);
        release_instr();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_rtype();
        word_t   a;
        word_t   b;
        word_t   r;
        funct3_t f3;
        logic    alt;
        for (int n = 0; n < 40; n++) begin
            // Eight funct3 codes, then SUB and SRA
            alt = (n % 10) >= 8;
            f3  = (n % 10 == 8) ? F3_ADD : (n % 10 == 9) ? F3_SR : funct3_t'(n % 10);
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            run_exec(enc_r(alt, f3, r[4:0]), r[4:0], a, b, ref_op(f3, alt, a, b));
        end
    endtask

    task automatic test_itype();
        word_t       a;
        word_t       b;
        word_t       r;
        funct3_t     f3;
        logic        alt;
        logic [11:0] imm;
        shamt_t      sh;
        for (int n = 0; n < 48; n++) begin
            f3  = funct3_t'(n % 8);
            a   = next_rand();
            r   = next_rand();
            imm = r[11:0];
            alt = 1'b0;
            if (f3 == F3_SLL || f3 == F3_SR) begin
                // Amounts 0 and 31 first, random after
                sh  = (n < 8) ? 5'd0 : (n < 16) ? 5'd31 : r[4:0];
                alt = (f3 == F3_SR) && n[3];
                imm = {1'b0, alt, 5'b0, sh};
            end else if (f3 == F3_SLTU && n < 24) begin
                imm[11] = 1'b1;
            end
            b = {{20{imm[11]}}, imm};
            run_exec(enc_i(imm, f3, r[20:16], OPC_ARITH_I), r[20:16], a, b,
                     ref_op(f3, alt, a, b));
        end
    endtask

    task automatic test_lui();
        word_t r;
        for (int n = 0; n < 8; n++) begin
            r = next_rand();
            run_exec({r[31:12], r[11:7], OPC_LUI}, r[11:7], next_rand(), next_rand(),
                     {r[31:12], 12'h0});
        end
    endtask

    task automatic test_mem(input logic store, input int unsigned wait_cycles);
        word_t       a;
        word_t       b;
        word_t       full;
        funct3_t     f3;
        logic [11:0] imm;
        logic [15:0] ea;
        int          waited;
        mem_wait = wait_cycles;
        for (int n = 0; n < 10; n++) begin
            case (n % 5)
                0:       f3 = F3_B;
                1:       f3 = F3_H;
                2:       f3 = F3_W;
                3:       f3 = store ? F3_B : F3_BU;
                default: f3 = store ? F3_H : F3_HU;
            endcase
            a    = next_rand();
            b    = next_rand();
            imm  = 12'(next_rand());
            full = a + {{20{imm[11]}}, imm};
            ea   = full[15:0];
            if (store) begin
                issue(enc_s(imm, f3), a, b);
            end else begin
                issue(enc_i(imm, f3, b[11:7], OPC_LOAD), a, b);
            end
            wait_ready(waited);
            check_word("mem_addr", word_t'(mem_addr), word_t'(ea));
            check_word("latency", waited, wait_cycles);
            check_bit("mem_ready", mem_ready, 1'b1);
            check_bit("mem_wr", mem_wr, store);
            check_bit("rd_wr", rd_wr, !store);
            if (store) begin
                check_word("mem_wdata", mem_wdata, b);
                check_word("mem_strb", word_t'(mem_strb), word_t'(lane_mask(f3)));
            end else begin
                check_word("rd_val", rd_val, load_ext(f3, mem_word(ea)));
                check_word("rd_strb", word_t'(rd_strb), word_t'(lane_mask(f3)));
            end
            release_instr();
        end
    endtask

    // Branch, JAL and AUIPC are outside the unit
    task automatic test_unsupported();
        word_t   r;
        opcode_t opc;
        int      waited;
        for (int n = 0; n < 3; n++) begin
            r   = next_rand();
            opc = (n == 0) ? 7'b1100011 : (n == 1) ? 7'b1101111 : 7'b0010111;
            issue({r[31:7], opc}, next_rand(), next_rand());
            wait_ready(waited);
            check_bit("rd_wr", rd_wr, 1'b0);
            check_bit("mem_en", mem_en, 1'b0);
            check_word("latency", waited, 0);
            release_instr();
        end
    endtask

    initial begin
        aresetn   = 1'b0;
        alu_en    = 1'b0;
        alu_instr = '0;
        mem_wait  = 0;
        errors    = 0;
        rng       = 32'hd7a7;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        // Each byte mixes every address bit
        for (int i = 0; i < 2**ADDRW; i++) begin
            mem[i] = i[7:0] ^ {i[11:8], i[15:12]} ^ 8'h3c;
        end
        repeat (5) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        check_bit("alu_ready", alu_ready, 1'b0);
        check_bit("rd_wr", rd_wr, 1'b0);
        check_bit("mem_en", mem_en, 1'b0);

        test_rtype();
        test_itype();
        test_lui();
        test_mem(1'b1, 0);
        test_mem(1'b1, 3);
        test_mem(1'b0, 0);
        test_mem(1'b0, 2);
        test_unsupported();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
